/* src/dma_settings.svh */
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// channel count and data widths
`define DMA_CHANNELS 4
`define DMA_BYTE_W 8
`define DMA_WORD_W 16

// width of the programming register address
`define DMA_REG_ADDR_W 4

// register map
// addresses 0..7: channel n address at 2n, word count at 2n+1
`define DMA_REG_CMD 8
`define DMA_REG_CLRFF 12

// command register bit positions within the written byte
`define DMA_CMD_ENABLE 0
`define DMA_CMD_ROTATING 1
`define DMA_CMD_READ 2

`endif

/* src/dmaPkg.sv */
`include "dma_settings.svh"

package dmaPkg;

	// one channel address or word count
	typedef logic [`DMA_WORD_W-1:0] chanWord_t;

	// channel number
	typedef logic [$clog2(`DMA_CHANNELS)-1:0] chanIdx_t;

	// one bit per channel, used for dreq, masks and grants
	typedef logic [`DMA_CHANNELS-1:0] chanVec_t;

	// single programming write, applied at the next clock edge
	typedef struct packed {
		logic wr;
		logic [`DMA_REG_ADDR_W-1:0] regAddr;
		logic [`DMA_BYTE_W-1:0] data;
	} progWrite_t;

	// bus master outputs, strobes are active low
	typedef struct packed {
		logic aen;
		logic adstb;
		chanVec_t dack;
		logic ioRdN;
		logic ioWrN;
		logic memRdN;
		logic memWrN;
	} busCycle_t;

	// command register, readXfer means memory to IO
	typedef struct packed {
		logic enable;
		logic rotating;
		logic readXfer;
	} cmdReg_t;

	// one-hot transfer sequencer states
	typedef enum logic [4:0] {
		stIdle = 5'b00001,
		stHold = 5'b00010,
		stS1   = 5'b00100,
		stS2   = 5'b01000,
		stS4   = 5'b10000
	} seqState_t;

endpackage

/* src/chanRegBank.sv */
`include "dma_settings.svh"

module chanRegBank import dmaPkg::*; #(
	parameter type wordT = chanWord_t
) (
	input logic busIf,
	input logic rstN,
	input chanVec_t loadEn,
	input logic loadHigh,
	input logic [`DMA_BYTE_W-1:0] loadByte,
	input logic stepEn,
	input chanIdx_t stepIdx,
	input wordT stepValue,
	output wordT baseValue [`DMA_CHANNELS],
	output wordT currentValue [`DMA_CHANNELS]
);

	localparam int WordW = $bits(wordT);
	localparam int ByteW = `DMA_BYTE_W;

	// replace the low or high byte of a stored word
	function automatic wordT putByte(wordT oldValue, logic high, logic [ByteW-1:0] newByte);
		logic [WordW-1:0] v;
		v = oldValue;
		if (high)
			v[WordW-1 -: ByteW] = newByte;
		else
			v[ByteW-1:0] = newByte;
		return wordT'(v);
	endfunction

	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			for (int ch = 0; ch < `DMA_CHANNELS; ch++)
			begin
				baseValue[ch] <= '0;
				currentValue[ch] <= '0;
			end
		end
		else
		begin
			for (int ch = 0; ch < `DMA_CHANNELS; ch++)
			begin
				// programming wins over a step on the same channel
				if (loadEn[ch])
				begin
					baseValue[ch] <= putByte(baseValue[ch], loadHigh, loadByte);
					// current follows base so both match after the high byte
					currentValue[ch] <= putByte(baseValue[ch], loadHigh, loadByte);
				end
				else if (stepEn && stepIdx == chanIdx_t'(ch))
					currentValue[ch] <= stepValue;
			end
		end
	end

endmodule

/* src/progRegs.sv */
`include "dma_settings.svh"

module progRegs import dmaPkg::*; (
	input logic busIf,
	input logic rstN,
	input progWrite_t progIn,
	input logic stepEn,
	input logic tc,
	input chanIdx_t stepIdx,
	input chanWord_t nextAddr,
	input chanWord_t nextCount,
	output cmdReg_t cmd,
	output chanVec_t chanMask,
	output chanWord_t curAddr [`DMA_CHANNELS],
	output chanWord_t curCount [`DMA_CHANNELS]
);

	// byte pointer, low byte first
	logic bytePtr;
	logic bankWr;
	logic cmdWr;
	logic clrWr;
	chanIdx_t wrChan;
	chanVec_t chanSel;
	chanVec_t addrLoad;
	chanVec_t countLoad;

	// address decode
	// regAddr below 2*channels hits a bank, bit 0 picks count over address
	assign bankWr = progIn.wr
		&& (progIn.regAddr < `DMA_REG_ADDR_W'(2 * `DMA_CHANNELS));
	assign cmdWr = progIn.wr && (progIn.regAddr == `DMA_REG_ADDR_W'(`DMA_REG_CMD));
	assign clrWr = progIn.wr && (progIn.regAddr == `DMA_REG_ADDR_W'(`DMA_REG_CLRFF));
	assign wrChan = chanIdx_t'(progIn.regAddr >> 1);
	assign chanSel = chanVec_t'(1) << wrChan;
	assign addrLoad = (bankWr && !progIn.regAddr[0]) ? chanSel : '0;
	assign countLoad = (bankWr && progIn.regAddr[0]) ? chanSel : '0;

	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			bytePtr <= 1'b0;
			cmd <= '0;
			// every channel starts masked
			chanMask <= '1;
		end
		else
		begin
			if (clrWr)
				bytePtr <= 1'b0;
			else if (bankWr)
				bytePtr <= ~bytePtr;

			if (cmdWr)
			begin
				cmd.enable <= progIn.data[`DMA_CMD_ENABLE];
				cmd.rotating <= progIn.data[`DMA_CMD_ROTATING];
				cmd.readXfer <= progIn.data[`DMA_CMD_READ];
			end

			for (int ch = 0; ch < `DMA_CHANNELS; ch++)
			begin
				// high count byte arms the channel, terminal count masks it
				if (countLoad[ch] && bytePtr)
					chanMask[ch] <= 1'b0;
				else if (tc && stepIdx == chanIdx_t'(ch))
					chanMask[ch] <= 1'b1;
			end
		end
	end

	// base copies stay inside the banks
	chanRegBank #(.wordT(chanWord_t)) i_addrBank (
		.busIf(busIf),
		.rstN(rstN),
		.loadEn(addrLoad),
		.loadHigh(bytePtr),
		.loadByte(progIn.data),
		.stepEn(stepEn),
		.stepIdx(stepIdx),
		.stepValue(nextAddr),
		.baseValue(),
		.currentValue(curAddr)
	);

	chanRegBank #(.wordT(chanWord_t)) i_countBank (
		.busIf(busIf),
		.rstN(rstN),
		.loadEn(countLoad),
		.loadHigh(bytePtr),
		.loadByte(progIn.data),
		.stepEn(stepEn),
		.stepIdx(stepIdx),
		.stepValue(nextCount),
		.baseValue(),
		.currentValue(curCount)
	);

endmodule

/* src/priorityArbiter.sv */
`include "dma_settings.svh"

module priorityArbiter import dmaPkg::*; (
	input logic busIf,
	input logic rstN,
	input chanVec_t dreq,
	input chanVec_t chanMask,
	input logic rotating,
	input logic served,
	input chanIdx_t servedIdx,
	output chanVec_t winner,
	output chanIdx_t winnerIdx
);

	// channel with the highest priority in rotating mode
	chanIdx_t rotBase;
	chanIdx_t startIdx;
	chanIdx_t probe;
	chanVec_t active;
	logic found;

	assign active = dreq & ~chanMask;

	// rotation moves past the channel just served
	always_ff @(posedge busIf)
	begin
		if (!rstN)
			rotBase <= '0;
		else if (served)
			rotBase <= servedIdx + 1'b1;
	end

	// scan from the start channel, wrapping round
	// fixed mode always starts at channel 0
	always_comb
	begin
		startIdx = rotating ? rotBase : '0;
		found = 1'b0;
		winnerIdx = '0;
		probe = '0;
		for (int k = 0; k < `DMA_CHANNELS; k++)
		begin
			probe = chanIdx_t'(int'(startIdx) + k);
			if (!found && active[probe])
			begin
				found = 1'b1;
				winnerIdx = probe;
			end
		end
		// one-hot grant, zero when nothing is pending
		winner = found ? (chanVec_t'(1) << winnerIdx) : '0;
	end

endmodule

/* src/transferSeq.sv */
`include "dma_settings.svh"

module transferSeq import dmaPkg::*; (
	input logic busIf,
	input logic rstN,
	input cmdReg_t cmd,
	input chanVec_t winner,
	input chanIdx_t winnerIdx,
	input chanWord_t curAddr [`DMA_CHANNELS],
	input chanWord_t curCount [`DMA_CHANNELS],
	input logic hlda,
	output logic hrq,
	output busCycle_t bus,
	output chanWord_t address,
	output logic served,
	output logic stepEn,
	output logic tc,
	output chanIdx_t stepIdx,
	output chanWord_t nextAddr,
	output chanWord_t nextCount
);

	seqState_t state;
	// channel being served in this cycle sequence
	chanIdx_t latchIdx;
	chanWord_t selAddr;
	chanWord_t selCount;

	assign selAddr = curAddr[latchIdx];
	assign selCount = curCount[latchIdx];

	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			latchIdx <= '0;
		end
		else
		begin
			unique case (state)
				stIdle:
				begin
					// grab the winner and ask for the bus
					if (cmd.enable && |winner)
					begin
						latchIdx <= winnerIdx;
						state <= stHold;
					end
				end
				stHold:
				begin
					// wait here as long as the CPU keeps the bus
					if (hlda)
						state <= stS1;
				end
				stS1:
					state <= stS2;
				stS2:
					state <= stS4;
				stS4:
					state <= stIdle;
				default:
					state <= stIdle;
			endcase
		end
	end

	// hold request covers the whole sequence past idle
	assign hrq = (state != stIdle);

	// bus cycle outputs decoded from state
	always_comb
	begin
		bus.aen = (state == stS1) || (state == stS2);
		bus.adstb = (state == stS1);
		bus.dack = (state == stS2) ? (chanVec_t'(1) << latchIdx) : '0;
		bus.ioRdN = 1'b1;
		bus.ioWrN = 1'b1;
		bus.memRdN = 1'b1;
		bus.memWrN = 1'b1;
		if (state == stS2)
		begin
			// memory to IO
			if (cmd.readXfer)
			begin
				bus.memRdN = 1'b0;
				bus.ioWrN = 1'b0;
			end
			// IO to memory
			else
			begin
				bus.ioRdN = 1'b0;
				bus.memWrN = 1'b0;
			end
		end
	end

	// address valid while aen is up
	assign address = bus.aen ? selAddr : '0;

	// S4 steps the current registers of the latched channel
	assign stepEn = (state == stS4);
	assign served = (state == stS4);
	assign stepIdx = latchIdx;
	assign nextAddr = selAddr + 1'b1;
	assign nextCount = selCount - 1'b1;
	// count of zero means this was the last transfer
	assign tc = (state == stS4) && (selCount == '0);

endmodule

/* src/dmaTop.sv */
`include "dma_settings.svh"

module dmaTop import dmaPkg::*; (
	input logic busIf,
	input logic rstN,
	input progWrite_t progIn,
	input chanVec_t dreq,
	input logic hlda,
	output logic hrq,
	output busCycle_t bus,
	output chanWord_t address,
	output logic tc
);

	cmdReg_t cmd;
	chanVec_t chanMask;
	chanWord_t curAddr [`DMA_CHANNELS];
	chanWord_t curCount [`DMA_CHANNELS];
	chanVec_t winner;
	chanIdx_t winnerIdx;
	logic served;
	logic stepEn;
	chanIdx_t stepIdx;
	chanWord_t nextAddr;
	chanWord_t nextCount;

	// programming registers and channel masks
	progRegs i_progRegs (
		.busIf(busIf),
		.rstN(rstN),
		.progIn(progIn),
		.stepEn(stepEn),
		.tc(tc),
		.stepIdx(stepIdx),
		.nextAddr(nextAddr),
		.nextCount(nextCount),
		.cmd(cmd),
		.chanMask(chanMask),
		.curAddr(curAddr),
		.curCount(curCount)
	);

	// request arbitration, rotation follows the served channel
	priorityArbiter i_arbiter (
		.busIf(busIf),
		.rstN(rstN),
		.dreq(dreq),
		.chanMask(chanMask),
		.rotating(cmd.rotating),
		.served(served),
		.servedIdx(stepIdx),
		.winner(winner),
		.winnerIdx(winnerIdx)
	);

	// bus master sequencer
	transferSeq i_seq (
		.busIf(busIf),
		.rstN(rstN),
		.cmd(cmd),
		.winner(winner),
		.winnerIdx(winnerIdx),
		.curAddr(curAddr),
		.curCount(curCount),
		.hlda(hlda),
		.hrq(hrq),
		.bus(bus),
		.address(address),
		.served(served),
		.stepEn(stepEn),
		.tc(tc),
		.stepIdx(stepIdx),
		.nextAddr(nextAddr),
		.nextCount(nextCount)
	);

endmodule

/* verif/dmaTb_chk.sv */
module dmaProtocolChk import dmaPkg::*; (
	input logic busIf,
	input logic rstN,
	input logic hrq,
	input logic hlda,
	input logic tc,
	input logic readXfer,
	input busCycle_t bus,
	input seqState_t seqState
);

	timeunit 1ns;
	timeprecision 1ps;

	// read by the testbench at the end of the run
	int failCount = 0;

	// everything quiet and strobes high the cycle after reset
	assert property (@(posedge busIf) !rstN |=> (!hrq && !tc && !bus.aen && !bus.adstb
		&& bus.dack == '0 && bus.ioRdN && bus.ioWrN && bus.memRdN && bus.memWrN))
	else
	begin
		$error("bus outputs active after reset");
		failCount++;
	end

	// hold request stays up until the CPU gives the bus
	assert property (@(posedge busIf) disable iff (!rstN)
		(hrq && !hlda) |=> hrq)
	else
	begin
		$error("hrq dropped while hlda was low");
		failCount++;
	end

	// S1 follows the first edge with hlda high
	assert property (@(posedge busIf) disable iff (!rstN)
		(seqState == stHold && hlda) |=> (bus.adstb && bus.aen))
	else
	begin
		$error("address strobe did not follow hlda");
		failCount++;
	end

	// adstb lasts one cycle
	assert property (@(posedge busIf) disable iff (!rstN) bus.adstb |=> !bus.adstb)
	else
	begin
		$error("adstb high for more than one cycle");
		failCount++;
	end

	// aen lasts exactly two cycles
	assert property (@(posedge busIf) disable iff (!rstN) $rose(bus.aen) |=> bus.aen)
	else
	begin
		$error("aen high for only one cycle");
		failCount++;
	end

	assert property (@(posedge busIf) disable iff (!rstN)
		(bus.aen && $past(bus.aen)) |=> !bus.aen)
	else
	begin
		$error("aen high for more than two cycles");
		failCount++;
	end

	// dack right after the address strobe, never two channels
	assert property (@(posedge busIf) disable iff (!rstN) bus.adstb |=> bus.dack != '0)
	else
	begin
		$error("dack did not follow adstb");
		failCount++;
	end

	assert property (@(posedge busIf) disable iff (!rstN) $onehot0(bus.dack))
	else
	begin
		$error("dack has more than one channel set");
		failCount++;
	end

	// memory to IO
	assert property (@(posedge busIf) disable iff (!rstN)
		(bus.dack != '0 && readXfer) |-> (!bus.memRdN && !bus.ioWrN))
	else
	begin
		$error("memRdN and ioWrN not both low in a read transfer");
		failCount++;
	end

	// IO to memory
	assert property (@(posedge busIf) disable iff (!rstN)
		(bus.dack != '0 && !readXfer) |-> (!bus.ioRdN && !bus.memWrN))
	else
	begin
		$error("ioRdN and memWrN not both low in a write transfer");
		failCount++;
	end

	assert property (@(posedge busIf) disable iff (!rstN) !(!bus.ioRdN && !bus.ioWrN))
	else
	begin
		$error("ioRdN and ioWrN low together");
		failCount++;
	end

endmodule

bind dmaTop dmaProtocolChk i_chk (
	.busIf(busIf),
	.rstN(rstN),
	.hrq(hrq),
	.hlda(hlda),
	.tc(tc),
	.readXfer(cmd.readXfer),
	.bus(bus),
	.seqState(i_seq.state)
);

/* verif/dmaTb.sv */
`include "dma_settings.svh"

module dmaTb import dmaPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WaitLimit = 50;

	logic busIf;
	logic rstN;
	progWrite_t progIn;
	chanVec_t dreq;
	logic hlda;
	logic hrq;
	busCycle_t bus;
	chanWord_t address;
	logic tc;

	int seed = 32'h1dc0;
	int fails = 0;
	int failsAtStart = 0;
	int testCount = 0;
	int failedTests = 0;
	int totalFails;

	// expected channel state, kept from the programming rules
	chanVec_t modelMask = '1;
	chanWord_t modelAddr [`DMA_CHANNELS];
	int remaining [`DMA_CHANNELS];
	logic modelRot = 1'b0;
	int rotNext = 0;

	dmaTop i_dmaTop (
		.busIf(busIf),
		.rstN(rstN),
		.progIn(progIn),
		.dreq(dreq),
		.hlda(hlda),
		.hrq(hrq),
		.bus(bus),
		.address(address),
		.tc(tc)
	);

	initial
	begin
		busIf = 1'b0;
		forever #10 busIf = ~busIf;
	end

	task automatic expectValue(input string name, input logic [15:0] got,
		input logic [15:0] want);
		assert (got === want)
		else
		begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
			fails++;
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("timeout at %0t: %s", $time, what);
		fails++;
	endtask

	// one programming write, held for one clock
	task automatic writeReg(input logic [`DMA_REG_ADDR_W-1:0] regAddr,
		input logic [`DMA_BYTE_W-1:0] data);
		@(negedge busIf);
		progIn = '{wr: 1'b1, regAddr: regAddr, data: data};
		@(negedge busIf);
		progIn.wr = 1'b0;
	endtask

	task automatic setCommand(input logic enable, input logic rotating, input logic readXfer);
		logic [`DMA_BYTE_W-1:0] value;
		value = '0;
		value[`DMA_CMD_ENABLE] = enable;
		value[`DMA_CMD_ROTATING] = rotating;
		value[`DMA_CMD_READ] = readXfer;
		writeReg(`DMA_REG_ADDR_W'(`DMA_REG_CMD), value);
		modelRot = rotating;
	endtask

	// address then count, low byte first, pointer cleared on both sides
	task automatic programChan(input int ch, input chanWord_t addr, input chanWord_t count);
		logic [`DMA_REG_ADDR_W-1:0] base;
		base = `DMA_REG_ADDR_W'(2 * ch);
		writeReg(`DMA_REG_ADDR_W'(`DMA_REG_CLRFF), '0);
		writeReg(base, addr[`DMA_BYTE_W-1:0]);
		writeReg(base, addr[2*`DMA_BYTE_W-1:`DMA_BYTE_W]);
		writeReg(base + `DMA_REG_ADDR_W'(1), count[`DMA_BYTE_W-1:0]);
		writeReg(base + `DMA_REG_ADDR_W'(1), count[2*`DMA_BYTE_W-1:`DMA_BYTE_W]);
		writeReg(`DMA_REG_ADDR_W'(`DMA_REG_CLRFF), '0);
		modelAddr[ch] = addr;
		remaining[ch] = int'(count) + 1;
		modelMask[ch] = 1'b0;
	endtask

	// first request from the start channel on, wrapping round
	function automatic int pickChannel(chanVec_t active, logic rot, int start);
		int idx;
		for (int k = 0; k < `DMA_CHANNELS; k++)
		begin
			idx = ((rot ? start : 0) + k) % `DMA_CHANNELS;
			if (active[idx])
				return idx;
		end
		return -1;
	endfunction

	// answer one hold request and record what the bus showed
	task automatic runTransfer(output chanWord_t seenAddr, output chanVec_t seenDack,
		output logic seenTc, output logic done);
		int n;
		int delay;
		seenAddr = '0;
		seenDack = '0;
		seenTc = 1'b0;
		done = 1'b0;
		n = 0;
		while (!hrq && n < WaitLimit)
		begin
			@(negedge busIf);
			n++;
		end
		if (!hrq)
		begin
			reportTimeout("hrq never rose for a pending request");
			return;
		end
		// CPU lets go of the bus 0 to 3 cycles later
		delay = $random(seed) & 3;
		repeat (delay) @(negedge busIf);
		hlda = 1'b1;
		n = 0;
		while (!bus.adstb && n < WaitLimit)
		begin
			@(negedge busIf);
			n++;
		end
		if (!bus.adstb)
		begin
			reportTimeout("adstb never rose after hlda");
			hlda = 1'b0;
			return;
		end
		seenAddr = address;
		n = 0;
		while (bus.dack == '0 && n < WaitLimit)
		begin
			@(negedge busIf);
			n++;
		end
		if (bus.dack == '0)
		begin
			reportTimeout("dack never rose after adstb");
			hlda = 1'b0;
			return;
		end
		seenDack = bus.dack;
		n = 0;
		// tc shows up in S4, just before hrq falls
		while (hrq && n < WaitLimit)
		begin
			if (tc)
				seenTc = 1'b1;
			@(negedge busIf);
			n++;
		end
		hlda = 1'b0;
		if (hrq)
		begin
			reportTimeout("hrq stayed high after the transfer");
			return;
		end
		done = 1'b1;
	endtask

	// hold a request pattern for a number of transfers, checking each one
	task automatic runBatch(input chanVec_t req, input int count);
		chanWord_t seenAddr;
		chanVec_t seenDack;
		logic seenTc;
		logic done;
		int ch;
		dreq = req;
		for (int t = 0; t < count; t++)
		begin
			ch = pickChannel(req & ~modelMask, modelRot, rotNext);
			if (ch < 0)
			begin
				$display("no channel left to serve for dreq %b", req);
				fails++;
				return;
			end
			runTransfer(seenAddr, seenDack, seenTc, done);
			if (!done)
				return;
			remaining[ch]--;
			expectValue("dack", 16'(seenDack), 16'(chanVec_t'(1) << ch));
			expectValue("address", seenAddr, modelAddr[ch]);
			expectValue("tc", 16'(seenTc), 16'(remaining[ch] == 0));
			modelAddr[ch]++;
			rotNext = (ch + 1) % `DMA_CHANNELS;
			if (remaining[ch] == 0)
				modelMask[ch] = 1'b1;
		end
	endtask

	task automatic startTest();
		failsAtStart = fails;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (fails != failsAtStart)
			failedTests++;
		$display("test %s: %s", name, (fails == failsAtStart) ? "ok" : "errors");
	endtask

	initial
	begin
		rstN = 1'b0;
		progIn = '0;
		dreq = '0;
		hlda = 1'b0;
		repeat (16) @(negedge busIf);
		rstN = 1'b1;

		// all channels start masked, so nothing is served
		startTest();
		setCommand(1'b1, 1'b0, 1'b0);
		dreq = '1;
		repeat (20)
		begin
			@(negedge busIf);
			expectValue("hrq", 16'(hrq), 16'h0000);
		end
		dreq = '0;
		finishTest("reset");

		startTest();
		programChan(1, 16'h12ab, 16'd2);
		runBatch(4'b0010, 3);
		// channel is masked after terminal count
		repeat (20)
		begin
			@(negedge busIf);
			expectValue("dack", 16'(bus.dack), 16'h0000);
			expectValue("hrq", 16'(hrq), 16'h0000);
		end
		dreq = '0;
		finishTest("programming");

		startTest();
		setCommand(1'b1, 1'b0, 1'b1);
		for (int ch = 0; ch < `DMA_CHANNELS; ch++)
			programChan(ch, chanWord_t'(16'h1000 * (ch + 1)), 16'd1);
		runBatch(4'b1110, 2);
		runBatch(4'b1111, 6);
		dreq = '0;
		finishTest("fixed priority");

		startTest();
		for (int ch = 0; ch < `DMA_CHANNELS; ch++)
			programChan(ch, chanWord_t'(16'h2000 + 16'h0100 * ch), 16'd1);
		setCommand(1'b1, 1'b1, 1'b0);
		runBatch(4'b1111, 5);
		dreq = '0;
		finishTest("rotating priority");

		totalFails = fails + i_dmaTop.i_chk.failCount;
		$display("tests %0d, failed tests %0d, errors %0d, assertion errors %0d",
			testCount, failedTests, fails, i_dmaTop.i_chk.failCount);
		if (totalFails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* list.f */
+incdir+src
src/dmaPkg.sv
src/chanRegBank.sv
src/progRegs.sv
src/priorityArbiter.sv
src/transferSeq.sv
src/dmaTop.sv
verif/dmaTb_chk.sv
verif/dmaTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= dmaTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and the variables"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
